//--- project.f
+incdir+.
cpu_pkg.sv
cpu_alu.sv
cpu_shift.sv
cpu_control.sv
cpu_datapath.sv
cpu6502.sv
tb_cpu6502.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_cpu6502
FILELIST = project.f
BUILD    = obj_dir

SOURCES  = $(shell grep -v '^+' $(FILELIST))
HEADERS  = tb_cpu_model.svh
BINARY   = $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

$(BINARY): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(BUILD)

//--- tb_cpu_model.svh
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

// Registers as the debug ports show them
typedef struct packed {
    logic [7:0] a;
    logic [7:0] x;
    logic [7:0] y;
    logic [7:0] p;
} reg_state_t;

typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  data;
} bus_write_t;

logic [7:0]  model_mem [0:65535];
logic [15:0] m_pc;
logic [7:0]  m_a, m_x, m_y;
logic        m_n, m_v, m_d, m_i, m_z, m_c;
bus_write_t  expected_writes [$];     // Bus writes still to come, oldest first

function automatic reg_state_t model_regs();
    return reg_state_t'{a: m_a, x: m_x, y: m_y, p: {m_n, m_v, 2'b11, m_d, m_i, m_z, m_c}};
endfunction

task automatic model_reset();
    m_pc = {model_mem[16'hfffd], model_mem[16'hfffc]};
    m_a  = 8'h00;
    m_x  = 8'h00;
    m_y  = 8'h00;
    {m_n, m_v, m_d, m_z, m_c} = 5'b00000;
    m_i  = 1'b1;                        // Interrupts masked after reset
endtask

task automatic set_nz(input logic [7:0] value);
    m_n = value[7];
    m_z = value == 8'h00;
endtask

task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
    model_mem[addr] = data;
    expected_writes.push_back(bus_write_t'{addr: addr, data: data});
endtask

// ASL ROL LSR ROR, then DEC and INC which keep C
task automatic shift_byte(input logic [2:0] group, inout logic [7:0] value);
    case (group)
        3'd0:    {m_c, value} = {value, 1'b0};
        3'd1:    {m_c, value} = {value, m_c};
        3'd2:    {value, m_c} = {1'b0, value};
        3'd3:    {value, m_c} = {m_c, value};
        3'd6:    value = value - 8'd1;
        default: value = value + 8'd1;
    endcase
    set_nz(value);
endtask

task automatic alu_op(input logic [2:0] group, input logic [7:0] m);
    logic [8:0] sum;
    sum = 9'h000;
    case (group)
        3'd0: m_a = m_a | m;
        3'd1: m_a = m_a & m;
        3'd2: m_a = m_a ^ m;
        3'd3: begin
            sum = {1'b0, m_a} + {1'b0, m} + {8'h00, m_c};
            m_v = (m_a[7] == m[7]) && (sum[7] != m_a[7]);
            m_c = sum[8];
            m_a = sum[7:0];
        end
        3'd6: begin
            m_c = m_a >= m;                  // Set when no borrow
            sum = {1'b0, m_a - m};
        end
        3'd7: begin
            sum = {1'b0, m_a} - {1'b0, m} - {8'h00, !m_c};
            m_v = (m_a[7] != m[7]) && (sum[7] != m_a[7]);
            m_c = !sum[8];                   // Borrow out clears C
            m_a = sum[7:0];
        end
        default: m_a = m;                    // LDA
    endcase
    set_nz(group == 3'd6 ? sum[7:0] : m_a);
endtask

// One whole instruction at m_pc
task automatic model_step(output int cycles, output logic rmw);
    logic [7:0]  op;
    logic [7:0]  lo;
    logic [7:0]  m;
    logic [15:0] ea;
    logic        implied;
    op      = model_mem[m_pc];
    lo      = model_mem[m_pc + 16'd1];
    ea      = op[3] ? {model_mem[m_pc + 16'd2], lo} : {8'h00, lo};
    rmw     = 1'b0;
    cycles  = 2;
    implied = 1'b1;
    case (op)
        8'haa: m_x = m_a;
        8'ha8: m_y = m_a;
        8'h8a: m_a = m_x;
        8'h98: m_a = m_y;
        8'he8: m_x = m_x + 8'd1;
        8'hc8: m_y = m_y + 8'd1;
        8'hca: m_x = m_x - 8'd1;
        8'h88: m_y = m_y - 8'd1;
        8'h18: m_c = 1'b0;
        8'h38: m_c = 1'b1;
        8'h58: m_i = 1'b0;
        8'h78: m_i = 1'b1;
        8'hb8: m_v = 1'b0;
        8'hd8: m_d = 1'b0;
        8'hf8: m_d = 1'b1;
        8'h0a, 8'h2a, 8'h4a, 8'h6a: shift_byte(op[7:5], m_a);
        default: implied = 1'b0;
    endcase
    if (op inside {8'haa, 8'he8, 8'hca})
        set_nz(m_x);
    else if (op inside {8'ha8, 8'hc8, 8'h88})
        set_nz(m_y);
    else if (op inside {8'h8a, 8'h98})
        set_nz(m_a);

    if (implied) begin
        m_pc = m_pc + 16'd1;
    end else if (op == cpu_pkg::opcode_jmp_abs) begin
        m_pc   = ea;
        cycles = 3;
    end else begin
        m      = op[2] ? model_mem[ea] : lo;    // Immediate modes have bit 2 clear
        m_pc   = m_pc + ((op[3] && op[2]) ? 16'd3 : 16'd2);
        cycles = op[2] ? (op[3] ? 4 : 3) : 2;
        if (op[7:5] == 3'd4) begin
            mem_write(ea, op[1:0] == 2'b00 ? m_y : op[1] ? m_x : m_a);
        end else if (op[0]) begin
            alu_op(op[7:5], m);
        end else if (op[7:5] == 3'd5 && op[1]) begin
            m_x = m;
            set_nz(m_x);
        end else if (op[7:5] == 3'd5) begin
            m_y = m;
            set_nz(m_y);
        end else begin
            mem_write(ea, m);                   // Old byte goes out first
            shift_byte(op[7:5], m);
            mem_write(ea, m);
            cycles = cycles + 2;
            rmw    = 1'b1;
        end
    end
endtask

`endif

//--- tb_cpu6502.sv
`default_nettype none

module tb_cpu6502;

    logic        clock = 1'b0;
    logic        reset;
    logic        enable;
    logic [7:0]  data_in;
    logic [15:0] address;
    logic [7:0]  data_out;
    logic        write_enable;
    logic        sync;
    logic [7:0]  debug_opcode;
    logic [15:0] debug_pc;
    logic [7:0]  debug_a, debug_x, debug_y, debug_p;

    logic [7:0]  mem [0:65535];

    `include "tb_cpu_model.svh"

    // Everything the core shows in one cycle
    typedef struct packed {
        logic [15:0] address;
        logic [7:0]  data_out;
        logic        write_enable;
        logic        sync;
        logic [7:0]  opcode;
        logic [15:0] pc;
        logic [7:0]  a;
        logic [7:0]  x;
        logic [7:0]  y;
        logic [7:0]  p;
    } bus_view_t;

    localparam logic [2:0] alu_groups [0:6] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};
    localparam logic [2:0] rmw_groups [0:5] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd6, 3'd7};
    localparam logic [1:0] store_classes [0:2] = '{2'b01, 2'b10, 2'b00};    // STA STX STY
    localparam logic [7:0] implied_ops [0:18] = '{
        8'h0a, 8'h2a, 8'h4a, 8'h6a, 8'haa, 8'ha8, 8'h8a, 8'h98, 8'he8, 8'hc8,
        8'hca, 8'h88, 8'h18, 8'h38, 8'h58, 8'h78, 8'hb8, 8'hd8, 8'hf8};

    bus_view_t seen;            // Sample from the previous falling edge
    logic      have_view;

    cpu6502 uut (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_in      (data_in),
        .address      (address),
        .data_out     (data_out),
        .write_enable (write_enable),
        .sync         (sync),
        .debug_opcode (debug_opcode),
        .debug_pc     (debug_pc),
        .debug_a      (debug_a),
        .debug_x      (debug_x),
        .debug_y      (debug_y),
        .debug_p      (debug_p)
    );

    always #20 clock = ~clock;

    // Reads are combinational, writes land on the rising edge
    assign data_in = mem[address];
    always @(posedge clock)
        if (enable && write_enable)
            mem[address] = data_out;

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report(input string why);
        $display("%s", why);
        stop_run();
    endtask

    task automatic check(input string name, input logic [95:0] expected,
                         input logic [95:0] actual);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s is %0h, expected %0h", $time, name, actual,
                     expected);
            stop_run();
        end
    endtask

    function automatic bus_view_t sample_view();
        return bus_view_t'{address: address, data_out: data_out,
                           write_enable: write_enable, sync: sync, opcode: debug_opcode,
                           pc: debug_pc, a: debug_a, x: debug_x, y: debug_y, p: debug_p};
    endfunction

    // One clock: sample, drive enable, check any write
    task automatic run_cycle(output logic sync_taken);
        bus_view_t  now;
        bus_write_t w;
        @(negedge clock);
        now = sample_view();
        if (have_view && !enable)
            check("outputs while enable low", 96'(seen), 96'(now));
        seen      = now;
        have_view = 1'b1;
        enable    = ($urandom % 4) != 0;     // Three cycles in four enabled
        sync_taken = enable && now.sync;
        if (enable && now.write_enable) begin
            if (expected_writes.size() == 0) begin
                report($sformatf("Write to %h that the model does not expect", now.address));
            end else begin
                w = expected_writes.pop_front();
                check("address", 96'(w.addr), 96'(now.address));
                check("data_out", 96'(w.data), 96'(now.data_out));
            end
        end
    endtask

    // Enabled cycles before the next enabled sync
    task automatic wait_sync(output int count);
        int   clocks;
        logic found;
        count  = 0;
        clocks = 0;
        found  = 1'b0;
        while (!found) begin
            run_cycle(found);
            clocks++;
            if (!found && enable)
                count++;
            if (count > 20 || clocks > 400)
                report("No sync within 20 enabled cycles");
        end
    endtask

    function automatic logic [2:0] read_mode(input logic [2:0] imm_mode);
        case ($urandom % 3)
            0:       return imm_mode;
            1:       return 3'b001;
            default: return 3'b011;
        endcase
    endfunction

    task automatic put_byte(inout logic [15:0] addr, input logic [7:0] value);
        mem[addr]       = value;
        model_mem[addr] = value;
        addr            = addr + 16'd1;
    endtask

    task automatic build_program(output logic [15:0] end_addr);
        logic [15:0] at;
        logic [7:0]  op;
        logic [2:0]  mem_mode;
        at = 16'h0200;
        for (int n = 0; n < 200; n++) begin
            mem_mode = ($urandom % 2) != 0 ? 3'b011 : 3'b001;
            case ($urandom % 5)
                0: op = {alu_groups[3'($urandom % 7)], read_mode(3'b010), 2'b01};
                1: op = {3'd4, mem_mode, store_classes[2'($urandom % 3)]};
                2: op = {3'd5, read_mode(3'b000), ($urandom % 2) != 0 ? 2'b10 : 2'b00};
                3: op = {rmw_groups[3'($urandom % 6)], mem_mode, 2'b10};
                default: op = implied_ops[5'($urandom % 19)];
            endcase
            put_byte(at, op);
            if (op[4:2] == 3'b001) begin
                put_byte(at, 8'h10 + 8'($urandom % 16));     // Zero page $10-$1F
            end else if (op[4:2] == 3'b011) begin
                put_byte(at, 8'($urandom % 16));             // Absolute $1000-$100F
                put_byte(at, 8'h10);
            end else if (op[0] || op[4:2] == 3'b000) begin
                put_byte(at, 8'($urandom));                  // Immediate
            end
        end
        end_addr = at;
        put_byte(at, cpu_pkg::opcode_jmp_abs);               // Spin here at the end
        put_byte(at, end_addr[7:0]);
        put_byte(at, end_addr[15:8]);
        at = 16'hfffc;
        put_byte(at, 8'h00);
        put_byte(at, 8'h02);
    endtask

    initial begin
        logic [15:0] end_addr;
        logic [15:0] loc;
        reg_state_t  lag;           // Registers two instructions back
        reg_state_t  now_regs;
        logic        prev_rmw;
        logic [7:0]  last_op;       // Opcode of the instruction finishing at this sync
        int          n;
        int          cycles;
        int          jmp_syncs;
        void'($urandom(30));
        reset     = 1'b1;
        enable    = 1'b0;
        have_view = 1'b0;
        for (int i = 0; i < 65536; i++) begin
            mem[16'(i)]       = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
            model_mem[16'(i)] = mem[16'(i)];
        end
        build_program(end_addr);
        model_reset();
        repeat (4) @(negedge clock);
        reset = 1'b0;

        // Two vector reads, no write before the first fetch
        wait_sync(n);
        check("cycles before first sync", 96'(2), 96'(n));
        lag       = model_regs();
        prev_rmw  = 1'b0;
        last_op   = cpu_pkg::opcode_jmp_abs;    // Reset starts inside a JMP
        jmp_syncs = 0;
        while (jmp_syncs < 2) begin
            now_regs = model_regs();
            check("pending writes", 96'(0), 96'(expected_writes.size()));
            check("debug_pc", 96'(m_pc), 96'(seen.pc));
            check("debug_opcode", 96'(last_op), 96'(seen.opcode));
            check("debug_a", 96'(lag.a), 96'(seen.a));
            check("debug_x", 96'(lag.x), 96'(seen.x));
            check("debug_y", 96'(lag.y), 96'(seen.y));
            // RMW flags land in modify2, one sync early
            check("debug_p", 96'(prev_rmw ? now_regs.p : lag.p), 96'(seen.p));
            lag = now_regs;
            if (m_pc == end_addr)
                jmp_syncs++;
            if (jmp_syncs < 2) begin
                last_op = model_mem[m_pc];
                model_step(cycles, prev_rmw);
                wait_sync(n);
                check("instruction cycles", 96'(cycles), 96'(n + 1));
            end
        end

        for (int i = 0; i < 16; i++) begin
            loc = 16'h0010 + 16'(i);
            check($sformatf("mem[%h]", loc), 96'(model_mem[loc]), 96'(mem[loc]));
            loc = 16'h1000 + 16'(i);
            check($sformatf("mem[%h]", loc), 96'(model_mem[loc]), 96'(mem[loc]));
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- cpu6502.sv
`default_nettype none

module cpu6502 (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic        enable,
    input  wire logic [7:0]  data_in,
    output logic [15:0]      address,
    output logic [7:0]       data_out,
    output logic             write_enable,
    output logic             sync,
    output logic [7:0]       debug_opcode,
    output logic [15:0]      debug_pc,
    output logic [7:0]       debug_a,
    output logic [7:0]       debug_x,
    output logic [7:0]       debug_y,
    output logic [7:0]       debug_p
);

    cpu_pkg::opcode_t opcode;
    cpu_pkg::ctrl_t   ctrl;
    logic [7:0]       data_reg;

    cpu_control control (
        .clock    (clock),
        .reset    (reset),
        .enable   (enable),
        .data_in  (data_in),
        .data_reg (data_reg),
        .opcode   (opcode),
        .byte1    (sync),       // Opcode fetch cycle
        .ctrl     (ctrl)
    );

    cpu_datapath datapath (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_in      (data_in),
        .opcode       (opcode),
        .ctrl         (ctrl),
        .data_reg     (data_reg),
        .address      (address),
        .data_out     (data_out),
        .write_enable (write_enable),
        .status       (debug_p),
        .pc           (debug_pc),
        .a            (debug_a),
        .x            (debug_x),
        .y            (debug_y)
    );

    assign debug_opcode = opcode.raw;

endmodule

`default_nettype wire

//--- cpu_datapath.sv
`default_nettype none

module cpu_datapath (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             enable,
    input  wire logic [7:0]       data_in,
    input  wire cpu_pkg::opcode_t opcode,
    input  wire cpu_pkg::ctrl_t   ctrl,
    output logic [7:0]            data_reg,
    output logic [15:0]           address,
    output logic [7:0]            data_out,
    output logic                  write_enable,
    output logic [7:0]            status,
    output logic [15:0]           pc,
    output logic [7:0]            a,
    output logic [7:0]            x,
    output logic [7:0]            y
);

    logic        flag_n, flag_v, flag_d, flag_i, flag_z, flag_c;
    logic [15:0] addr_reg;      // Last address, for the RMW writes
    logic [7:0]  low_byte;      // Previous registered byte
    logic [7:0]  alu_result, shift_result, rmw_result;
    logic        alu_carry, alu_overflow, shift_carry, rmw_carry;
    logic [7:0]  store_value;
    logic [7:0]  db;

    cpu_alu alu (
        .a         (a),
        .b         (data_reg),
        .carry_in  (flag_c),
        .op        (opcode.field.group),
        .result    (alu_result),
        .carry_out (alu_carry),
        .overflow  (alu_overflow)
    );

    // Accumulator shifts
    cpu_shift acc_shift (
        .value     (a),
        .carry_in  (flag_c),
        .op        (opcode.field.group),
        .result    (shift_result),
        .carry_out (shift_carry)
    );

    // Memory RMW on the byte just read
    cpu_shift mem_shift (
        .value     (data_reg),
        .carry_in  (flag_c),
        .op        (opcode.field.group),
        .result    (rmw_result),
        .carry_out (rmw_carry)
    );

    always_comb begin
        case (opcode.field.op_class)
            2'b00:   store_value = y;   // STY
            2'b10:   store_value = x;   // STX
            default: store_value = a;   // STA
        endcase
    end

    assign db = ctrl.db.data_in ? data_reg :
                ctrl.db.rmw     ? rmw_result :
                ctrl.db.alu     ? alu_result :
                ctrl.db.shift   ? shift_result :
                ctrl.db.a       ? a :
                ctrl.db.x       ? x :
                ctrl.db.y       ? y :
                ctrl.db.inc_x   ? x + 8'd1 :
                ctrl.db.inc_y   ? y + 8'd1 :
                ctrl.db.dec_x   ? x - 8'd1 :
                ctrl.db.dec_y   ? y - 8'd1 :
                8'h00;

    assign address = ctrl.addr.zp   ? {8'h00, data_reg} :
                     ctrl.addr.abs  ? {data_reg, low_byte} :    // High byte just read
                     ctrl.addr.hold ? addr_reg :
                     pc;

    assign data_out = ctrl.write.same  ? data_reg :
                      ctrl.write.rmw   ? rmw_result :
                      ctrl.write.store ? store_value :
                      8'h00;

    assign write_enable = ctrl.write.enable;
    assign status       = {flag_n, flag_v, 2'b11, flag_d, flag_i, flag_z, flag_c};

    always_ff @(posedge clock) begin
        if (reset) begin
            pc     <= cpu_pkg::reset_vector;
            a      <= 8'h00;
            x      <= 8'h00;
            y      <= 8'h00;
            flag_n <= 1'b0;
            flag_v <= 1'b0;
            flag_d <= 1'b0;
            flag_i <= 1'b1;     // Interrupts masked out of reset
            flag_z <= 1'b0;
            flag_c <= 1'b0;
        end else if (enable) begin
            pc <= ctrl.pc.vector ? {data_in, data_reg} : pc + 16'(ctrl.pc.increment);
            if (ctrl.a) a <= db;
            if (ctrl.x) x <= db;
            if (ctrl.y) y <= db;
            if (ctrl.n.db7) flag_n <= db[7];
            if (ctrl.z.dbz) flag_z <= db == 8'h00;
            if (ctrl.v.clear)    flag_v <= 1'b0;
            else if (ctrl.v.alu) flag_v <= alu_overflow;
            if (ctrl.d.ir5) flag_d <= opcode.field.group[0];   // Opcode bit 5 picks set or clear
            if (ctrl.i.ir5) flag_i <= opcode.field.group[0];
            if (ctrl.c.ir5)        flag_c <= opcode.field.group[0];
            else if (ctrl.c.alu)   flag_c <= alu_carry;
            else if (ctrl.c.rmw)   flag_c <= rmw_carry;
            else if (ctrl.c.shift) flag_c <= shift_carry;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            addr_reg <= address;
            low_byte <= data_reg;
            data_reg <= ctrl.write.enable ? data_out : data_in;  // Written byte reads back
        end
    end

    one_write_source: assert property (@(posedge clock) disable iff (reset)
        write_enable |-> $onehot({ctrl.write.same, ctrl.write.rmw, ctrl.write.store}));

endmodule

`default_nettype wire

//--- cpu_control.sv
`default_nettype none

module cpu_control (
    input  wire logic       clock,
    input  wire logic       reset,
    input  wire logic       enable,
    input  wire logic [7:0] data_in,
    input  wire logic [7:0] data_reg,
    output cpu_pkg::opcode_t opcode,
    output logic            byte1,
    output cpu_pkg::ctrl_t  ctrl
);

    cpu_pkg::state_t state;
    cpu_pkg::state_t next_state;

    logic implied, zp_mode, abs_mode;
    logic load_store, load, store, arith, modify, flag_op;
    logic acc_shift, cmp, adc_sbc, lda, ldx, ldy, set_nz;
    logic tax_tay, txa, tya, inx, iny, dex, dey;

    // Addressing modes
    assign implied  = opcode.field.mode[1:0] == 2'b10 && !opcode.field.op_class[0];
    assign zp_mode  = opcode.field.mode == 3'b001;
    assign abs_mode = opcode.field.mode == 3'b011;

    assign load_store = opcode.field.group[2:1] == 2'b10;
    assign load       = opcode.field.group == 3'b101;
    assign store      = opcode.field.group == 3'b100;
    assign arith      = opcode.field.op_class[0] && !load_store;
    assign modify     = opcode.field.op_class[1] && !load_store;
    assign flag_op    = opcode.field.mode == 3'b110 && opcode.field.op_class == 2'b00
                        && !store;                       // TYA shares the pattern
    assign acc_shift  = opcode.raw ==? 8'b0??_010_10;
    assign cmp        = arith && opcode.field.group == 3'b110;
    assign adc_sbc    = arith && opcode.field.group[1:0] == 2'b11;

    // Register loads, TAX and TAY fall under LDX and LDY
    assign lda = load && opcode.field.op_class[0];
    assign ldx = load && opcode.field.op_class[1];
    assign ldy = load && opcode.field.op_class == 2'b00 && !flag_op;   // Not CLV

    assign tax_tay = opcode.raw ==? 8'b101_010_?0;
    assign txa     = opcode.raw == 8'h8a;
    assign tya     = opcode.raw == 8'h98;
    assign inx     = opcode.raw == 8'he8;
    assign iny     = opcode.raw == 8'hc8;
    assign dex     = opcode.raw == 8'hca;
    assign dey     = opcode.raw == 8'h88;

    assign set_nz = (load && !flag_op) || arith || acc_shift
                    || txa || tya || inx || iny || dex || dey;

    always_comb begin
        ctrl       = '0;
        next_state = '0;

        if (state.byte1) begin
            // Opcode on the bus, previous instruction writes its registers
            next_state.byte2  = 1'b1;
            ctrl.pc.increment = 1'b1;

            ctrl.db.data_in = load && !implied;
            ctrl.db.alu     = arith;
            ctrl.db.shift   = acc_shift;
            ctrl.db.a       = tax_tay;
            ctrl.db.x       = txa;
            ctrl.db.y       = tya;
            ctrl.db.inc_x   = inx;
            ctrl.db.inc_y   = iny;
            ctrl.db.dec_x   = dex;
            ctrl.db.dec_y   = dey;

            ctrl.n.db7   = set_nz;
            ctrl.z.dbz   = set_nz;                      // CMP flags come from the difference
            ctrl.v.alu   = adc_sbc;
            ctrl.v.clear = flag_op && opcode.field.group == 3'b101;
            ctrl.c.alu   = adc_sbc || cmp;
            ctrl.c.shift = acc_shift;
            ctrl.c.ir5   = flag_op && opcode.field.group[2:1] == 2'b00;
            ctrl.i.ir5   = flag_op && opcode.field.group[2:1] == 2'b01;
            ctrl.d.ir5   = flag_op && opcode.field.group[2:1] == 2'b11;

            ctrl.a = lda || txa || tya || acc_shift || (arith && !cmp);
            ctrl.x = ldx || inx || dex;
            ctrl.y = ldy || iny || dey;
        end

        if (state.byte2) begin
            ctrl.pc.increment   = !implied;             // Immediate operand consumed
            next_state.zeropage = zp_mode;
            next_state.byte3    = abs_mode;
            next_state.byte1    = !zp_mode && !abs_mode;
        end

        if (state.byte3) begin
            if (opcode.raw == cpu_pkg::opcode_jmp_abs) begin
                ctrl.pc.vector   = 1'b1;
                next_state.byte1 = 1'b1;
            end else begin
                ctrl.pc.increment   = 1'b1;
                next_state.absolute = 1'b1;
            end
        end

        if (state.zeropage || state.absolute) begin
            ctrl.addr.zp       = state.zeropage;
            ctrl.addr.abs      = state.absolute;
            next_state.modify1 = modify;
            next_state.byte1   = !modify;
            ctrl.write.enable  = store;                 // Stores write in their last cycle
            ctrl.write.store   = store;
        end

        if (state.modify1) begin
            next_state.modify2 = 1'b1;
            ctrl.addr.hold     = 1'b1;
            ctrl.write.enable  = 1'b1;
            ctrl.write.same    = 1'b1;
        end

        if (state.modify2) begin
            next_state.byte1  = 1'b1;
            ctrl.addr.hold    = 1'b1;
            ctrl.write.enable = 1'b1;
            ctrl.write.rmw    = 1'b1;
            ctrl.db.rmw       = 1'b1;
            ctrl.n.db7        = 1'b1;
            ctrl.z.dbz        = 1'b1;
            ctrl.c.rmw        = !opcode.field.group[2];  // INC and DEC keep C
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= '{byte2: 1'b1, default: 1'b0};  // Mid-JMP, reads the vector next
            opcode.raw <= cpu_pkg::opcode_jmp_abs;
        end else if (enable) begin
            state <= next_state;
            if (state.byte1)
                opcode.raw <= data_in;
        end
    end

    assign byte1 = state.byte1;

    state_one_hot: assert property (@(posedge clock) disable iff (reset) $onehot(state));

    no_write_in_fetch: assert property (@(posedge clock) disable iff (reset)
        state.byte1 |-> !ctrl.write.enable);

    // Datapath input register and opcode latch take the same fetched byte
    opcode_matches_input: assert property (@(posedge clock) disable iff (reset)
        enable && state.byte1 |=> opcode.raw == data_reg);

endmodule

`default_nettype wire

//--- cpu_shift.sv
`default_nettype none

module cpu_shift (
    input  wire logic [7:0] value,
    input  wire logic       carry_in,
    input  wire logic [2:0] op,         // ASL ROL LSR ROR, 6 DEC, 7 INC
    output logic [7:0]      result,
    output logic            carry_out
);

    logic fill;

    assign fill = carry_in & op[0];     // Rotates shift the carry in

    always_comb begin
        if (op[2]) begin
            // Increment or decrement leaves C alone upstream
            result    = op[0] ? value + 8'd1 : value - 8'd1;
            carry_out = 1'b0;
        end else if (op[1]) begin
            result    = {fill, value[7:1]};   // LSR, ROR
            carry_out = value[0];
        end else begin
            result    = {value[6:0], fill};   // ASL, ROL
            carry_out = value[7];
        end
    end

endmodule

`default_nettype wire

//--- cpu_alu.sv
`default_nettype none

module cpu_alu (
    input  wire logic [7:0] a,
    input  wire logic [7:0] b,
    input  wire logic       carry_in,
    input  wire logic [2:0] op,         // ORA AND EOR ADC STA LDA CMP SBC
    output logic [7:0]      result,
    output logic            carry_out,
    output logic            overflow
);

    logic       subtract;
    logic       carry;
    logic [7:0] addend;
    logic [8:0] sum;

    assign subtract = op[2:1] == 2'b11;                // CMP and SBC
    assign addend   = subtract ? ~b : b;
    assign carry    = (op == 3'd6) | carry_in;         // CMP never borrows in
    assign sum      = {1'b0, a} + {1'b0, addend} + 9'(carry);

    always_comb begin
        case (op)
            3'd0:    result = a | b;
            3'd1:    result = a & b;
            3'd2:    result = a ^ b;
            3'd4:    result = 8'h00;                   // Stores never take the ALU
            3'd5:    result = b;
            default: result = sum[7:0];                // ADC, CMP, SBC
        endcase
    end

    // Signed overflow when both inputs agree in sign and the sum does not
    assign overflow  = (a[7] ^ sum[7]) & (addend[7] ^ sum[7]);
    assign carry_out = sum[8];

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam logic [15:0] reset_vector   = 16'hfffc;   // Low byte of the start address
    localparam logic [7:0]  opcode_jmp_abs = 8'h4c;

    // Opcode byte seen as aaa_bbb_cc
    typedef struct packed {
        logic [2:0] group;      // Operation inside the class
        logic [2:0] mode;       // Addressing mode
        logic [1:0] op_class;   // 00 index and misc, 01 ALU, 10 RMW
    } opcode_fields_t;

    typedef union packed {
        logic [7:0]     raw;    // Exact opcode compares
        opcode_fields_t field;  // Pattern decoding
    } opcode_t;

    // One-hot cycle state
    typedef struct packed {
        logic byte1;            // Fetch opcode and finish the previous instruction
        logic byte2;            // Fetch first operand byte
        logic byte3;            // Fetch high address byte
        logic zeropage;         // Access $00xx
        logic absolute;         // Access full 16-bit address
        logic modify1;          // Write back the unmodified byte
        logic modify2;          // Write back the result
    } state_t;

    typedef struct packed {
        struct packed {
            logic increment;    // PC + 1
            logic vector;       // PC from the last two bytes read
        } pc;
        struct packed {
            logic zp;           // $00 : registered byte
            logic abs;          // Registered byte : saved low byte
            logic hold;         // Repeat the last address
        } addr;
        struct packed {
            logic enable;
            logic same;         // Registered byte back out
            logic rmw;          // Memory shift unit result
            logic store;        // A, X or Y by opcode class
        } write;
        struct packed {
            logic data_in;
            logic rmw;
            logic alu;
            logic shift;
            logic a;
            logic x;
            logic y;
            logic inc_x;
            logic inc_y;
            logic dec_x;
            logic dec_y;
        } db;                   // Internal bus source, first set bit wins
        struct packed {
            logic db7;
        } n;
        struct packed {
            logic clear;        // CLV
            logic alu;          // ADC and SBC overflow
        } v;
        struct packed {
            logic ir5;
        } d;
        struct packed {
            logic ir5;
        } i;
        struct packed {
            logic dbz;
        } z;
        struct packed {
            logic ir5;          // CLC and SEC
            logic alu;
            logic rmw;
            logic shift;
        } c;
        logic a;                // Register loads from the bus
        logic x;
        logic y;
    } ctrl_t;

endpackage

`default_nettype wire
